//--- files.f
source/fpu_cfg_pkg.sv
source/fpu_types_pkg.sv
source/fpu_result_if.sv
source/fpu_noncomp.sv
source/fpu_mul.sv
source/fpu_result_arbiter.sv
source/fpu_top.sv
testbench/fpu_top_chk.sv
testbench/fpu_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FP16 unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fpu_top_tb \
  -f files.f --Mdir obj_dir -o fpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/fpu_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- source/fpu_cfg_pkg.sv
// ---------------------------------------------------------------------
// FPU configuration package
// Sizes and fixed encodings shared by the FP16 unit
// ---------------------------------------------------------------------

package fpu_cfg_pkg;

  // Operation groups behind the result arbiter
  localparam int unsigned NUM_OPGROUPS = 2;

  // Request identifier width
  localparam int unsigned TAG_WIDTH = 4;

  // Quiet NaN returned by every NaN-producing operation
  localparam logic [15:0] CANON_NAN = 16'h7E00;

  // Largest finite FP16 magnitude, used on overflow
  localparam logic [15:0] FP_MAX_FINITE = 16'h7BFF;

endpackage

//--- source/fpu_mul.sv
// ---------------------------------------------------------------------
// FPU multiplier group
// Two-stage FP16 multiply, truncating, subnormals flushed to zero
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module fpu_mul (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  fpu_types_pkg::fp16_t op_a_i,
  input  fpu_types_pkg::fp16_t op_b_i,
  input  fpu_types_pkg::tag_t  tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  fpu_result_if.group          res,
  output logic                 busy_o
);

  import fpu_cfg_pkg::*;
  import fpu_types_pkg::*;

  localparam int unsigned SB = EXP_WIDTH + MAN_WIDTH;
  localparam int unsigned PW = 2 * (MAN_WIDTH + 1);

  // Signed exponent with room for the sum and the bias
  typedef logic signed [EXP_WIDTH+1:0] sexp_t;
  typedef logic [PW-1:0]               prod_t;

  localparam sexp_t EXP_MAX = sexp_t'((1 << EXP_WIDTH) - 1);

  logic [EXP_WIDTH-1:0] ea, eb;
  logic [MAN_WIDTH-1:0] ma, mb;
  logic                 a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;

  assign ea = op_a_i[MAN_WIDTH +: EXP_WIDTH];
  assign eb = op_b_i[MAN_WIDTH +: EXP_WIDTH];
  assign ma = op_a_i[MAN_WIDTH-1:0];
  assign mb = op_b_i[MAN_WIDTH-1:0];

  // Zero exponent covers subnormals too
  assign a_zero = (ea == '0);
  assign b_zero = (eb == '0);
  assign a_inf  = (&ea) & (ma == '0);
  assign b_inf  = (&eb) & (mb == '0);
  assign a_nan  = (&ea) & (ma != '0);
  assign b_nan  = (&eb) & (mb != '0);

  // ------------------------------------------------------------------
  // Handshake, each stage moves when the next is free or draining
  // ------------------------------------------------------------------
  logic v1_q, v2_q;
  logic s1_ready, s2_ready, accept, s1_move;

  assign s2_ready   = ~v2_q | res.ready;
  assign s1_ready   = ~v1_q | s2_ready;
  assign in_ready_o = ~flush_i & s1_ready;
  assign accept     = in_valid_i & in_ready_o;
  assign s1_move    = v1_q & s2_ready;
  assign busy_o     = v1_q | v2_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else if (flush_i) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      if (s1_ready) v1_q <= accept;
      if (s2_ready) v2_q <= s1_move;
    end
  end

  // ------------------------------------------------------------------
  // Stage 1: sign, exponent sum, mantissa product
  // ------------------------------------------------------------------
  logic  sign1_q, zero1_q, inf1_q, nan1_q, snan1_q;
  sexp_t exp1_q;
  prod_t prod1_q;
  tag_t  tag1_q;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      sign1_q <= op_a_i[SB] ^ op_b_i[SB];
      exp1_q  <= sexp_t'(ea) + sexp_t'(eb) - sexp_t'(EXP_BIAS);
      prod1_q <= prod_t'({1'b1, ma}) * prod_t'({1'b1, mb});
      zero1_q <= a_zero | b_zero;
      inf1_q  <= a_inf | b_inf;
      nan1_q  <= a_nan | b_nan;
      snan1_q <= (a_nan & ~ma[MAN_WIDTH-1]) | (b_nan & ~mb[MAN_WIDTH-1]);
      tag1_q  <= tag_i;
    end
  end

  // ------------------------------------------------------------------
  // Stage 2: normalise, truncate, special cases
  // ------------------------------------------------------------------
  sexp_t                exp_n;
  logic [MAN_WIDTH-1:0] man_n;
  logic                 lost, inf_x_zero;
  fp16_t                res_d, result_q;
  status_t              st_d, status_q;
  tag_t                 tag_q;

  assign inf_x_zero = inf1_q & zero1_q;

  always_comb begin : normalise
    // Product in [1,4), a set top bit shifts one more place
    if (prod1_q[PW-1]) begin
      exp_n = exp1_q + sexp_t'(1);
      man_n = prod1_q[PW-2 -: MAN_WIDTH];
      lost  = |prod1_q[MAN_WIDTH:0];
    end else begin
      exp_n = exp1_q;
      man_n = prod1_q[PW-3 -: MAN_WIDTH];
      lost  = |prod1_q[MAN_WIDTH-1:0];
    end

    res_d = {sign1_q, exp_n[EXP_WIDTH-1:0], man_n};
    st_d  = {4'b0000, lost};
    if (nan1_q || inf_x_zero) begin
      res_d = CANON_NAN;
      st_d  = {snan1_q | inf_x_zero, 4'b0000};
    end else if (inf1_q) begin
      res_d = {sign1_q, {EXP_WIDTH{1'b1}}, {MAN_WIDTH{1'b0}}};
      st_d  = '0;
    end else if (zero1_q) begin
      res_d = {sign1_q, {SB{1'b0}}};
      st_d  = '0;
    end else if (exp_n >= EXP_MAX) begin
      // Truncation saturates at the largest finite value
      res_d = {sign1_q, FP_MAX_FINITE[SB-1:0]};
      st_d  = 5'b00101;
    end else if (exp_n < sexp_t'(1)) begin
      res_d = {sign1_q, {SB{1'b0}}};
      st_d  = 5'b00011;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_move) begin
      result_q <= res_d;
      status_q <= st_d;
      tag_q    <= tag1_q;
    end
  end

  assign res.valid  = v2_q;
  assign res.result = result_q;
  assign res.status = status_q;
  assign res.tag    = tag_q;

endmodule

//--- source/fpu_noncomp.sv
// ---------------------------------------------------------------------
// FPU non-computational group
// Min/max, sign injection, compares and classify in one cycle
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module fpu_noncomp (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  fpu_types_pkg::fp16_t   op_a_i,
  input  fpu_types_pkg::fp16_t   op_b_i,
  input  fpu_types_pkg::fpu_op_e op_i,
  input  fpu_types_pkg::tag_t    tag_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic                   flush_i,
  fpu_result_if.group            res
);

  import fpu_cfg_pkg::*;
  import fpu_types_pkg::*;

  // Sign bit position
  localparam int unsigned SB = EXP_WIDTH + MAN_WIDTH;

  // Class mask in classify bit order, sNaN at 8 and qNaN at 9
  function automatic logic [9:0] fp_class(input fp16_t v);
    logic [EXP_WIDTH-1:0] e;
    logic [MAN_WIDTH-1:0] m;
    logic [9:0]           cls;
    e   = v[MAN_WIDTH +: EXP_WIDTH];
    m   = v[MAN_WIDTH-1:0];
    cls = '0;
    if (&e) begin
      if (m == '0) cls[v[SB] ? 0 : 7] = 1'b1;
      else         cls[m[MAN_WIDTH-1] ? 9 : 8] = 1'b1;
    end else if (e == '0) begin
      if (m == '0) cls[v[SB] ? 3 : 4] = 1'b1;
      else         cls[v[SB] ? 2 : 5] = 1'b1;
    end else begin
      cls[v[SB] ? 1 : 6] = 1'b1;
    end
    return cls;
  endfunction

  logic [9:0] a_cls, b_cls;
  logic       a_nan, b_nan, any_snan;
  logic       both_zero, mag_lt, mag_eq, a_lt;
  logic       feq, flt, fle;
  fp16_t      res_d, result_q;
  status_t    st_d, status_q;
  tag_t       tag_q;
  logic       valid_q, accept;

  assign a_cls    = fp_class(op_a_i);
  assign b_cls    = fp_class(op_b_i);
  assign a_nan    = |a_cls[9:8];
  assign b_nan    = |b_cls[9:8];
  assign any_snan = a_cls[8] | b_cls[8];

  // Total order with -0 below +0, used by min and max
  assign mag_lt    = op_a_i[SB-1:0] < op_b_i[SB-1:0];
  assign mag_eq    = op_a_i[SB-1:0] == op_b_i[SB-1:0];
  assign a_lt      = (op_a_i[SB] != op_b_i[SB]) ? op_a_i[SB] :
                     (op_a_i[SB] ? ~(mag_lt | mag_eq) : mag_lt);
  assign both_zero = (a_cls[3] | a_cls[4]) & (b_cls[3] | b_cls[4]);

  // IEEE compares, signed zeros are equal
  assign feq = ~(a_nan | b_nan) & ((op_a_i == op_b_i) | both_zero);
  assign flt = ~(a_nan | b_nan) & a_lt & ~both_zero;
  assign fle = flt | feq;

  always_comb begin : compute
    res_d = '0;
    st_d  = '0;
    case (op_i)
      OP_MIN, OP_MAX: begin
        if (a_nan && b_nan)                 res_d = CANON_NAN;
        else if (a_nan)                     res_d = op_b_i;
        else if (b_nan)                     res_d = op_a_i;
        else if ((op_i == OP_MIN) == a_lt)  res_d = op_a_i;
        else                                res_d = op_b_i;
        st_d = {any_snan, 4'b0000};
      end
      OP_SGNJ:  res_d = {op_b_i[SB], op_a_i[SB-1:0]};
      OP_SGNJN: res_d = {~op_b_i[SB], op_a_i[SB-1:0]};
      OP_SGNJX: res_d = {op_a_i[SB] ^ op_b_i[SB], op_a_i[SB-1:0]};
      OP_FEQ: begin
        res_d = {{SB{1'b0}}, feq};
        st_d  = {any_snan, 4'b0000};
      end
      OP_FLT, OP_FLE: begin
        res_d = {{SB{1'b0}}, (op_i == OP_FLT) ? flt : fle};
        st_d  = {a_nan | b_nan, 4'b0000};
      end
      OP_CLASS: res_d = {{(SB-9){1'b0}}, a_cls};
      default:  res_d = '0;
    endcase
  end

  // ------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------
  assign in_ready_o = ~flush_i & (~valid_q | res.ready);
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (res.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      result_q <= res_d;
      status_q <= st_d;
      tag_q    <= tag_i;
    end
  end

  assign res.valid  = valid_q;
  assign res.result = result_q;
  assign res.status = status_q;
  assign res.tag    = tag_q;

endmodule

//--- source/fpu_result_arbiter.sv
// ---------------------------------------------------------------------
// FPU result arbiter
// Round-robin merge of the group result streams onto one output
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module fpu_result_arbiter (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  fpu_result_if.arb             grp [fpu_cfg_pkg::NUM_OPGROUPS],
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output fpu_types_pkg::fp16_t   result_o,
  output fpu_types_pkg::status_t status_o,
  output fpu_types_pkg::tag_t    tag_o
);

  import fpu_cfg_pkg::*;
  import fpu_types_pkg::*;

  localparam int unsigned PTR_W = (NUM_OPGROUPS > 1) ? $clog2(NUM_OPGROUPS) : 1;

  logic [NUM_OPGROUPS-1:0] req;
  fp16_t                   res_arr [NUM_OPGROUPS];
  status_t                 st_arr  [NUM_OPGROUPS];
  tag_t                    tag_arr [NUM_OPGROUPS];
  logic [PTR_W-1:0]        ptr_q, sel;

  for (genvar g = 0; g < int'(NUM_OPGROUPS); g++) begin : gen_unpack
    assign req[g]     = grp[g].valid;
    assign res_arr[g] = grp[g].result;
    assign st_arr[g]  = grp[g].status;
    assign tag_arr[g] = grp[g].tag;
    // Only the granted group sees the output ready
    assign grp[g].ready = out_ready_i & out_valid_o & (sel == PTR_W'(g));
  end

  // First requesting group at or after the pointer
  always_comb begin : grant
    int unsigned idx;
    logic        found;
    sel   = ptr_q;
    found = 1'b0;
    for (int unsigned i = 0; i < NUM_OPGROUPS; i++) begin
      idx = (int'(ptr_q) + i) % NUM_OPGROUPS;
      if (!found && req[idx]) begin
        found = 1'b1;
        sel   = PTR_W'(idx);
      end
    end
  end

  assign out_valid_o = |req;
  assign result_o    = res_arr[sel];
  assign status_o    = st_arr[sel];
  assign tag_o       = tag_arr[sel];

  // Priority moves past the group that just transferred
  // A stalled grant is kept so the output payload holds
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (flush_i) begin
      ptr_q <= '0;
    end else if (out_valid_o && out_ready_i) begin
      ptr_q <= (sel == PTR_W'(NUM_OPGROUPS - 1)) ? '0 : sel + PTR_W'(1);
    end else if (out_valid_o) begin
      ptr_q <= sel;
    end
  end

endmodule

//--- source/fpu_result_if.sv
// ---------------------------------------------------------------------
// FPU result stream
// One operation group's result channel towards the arbiter
// ---------------------------------------------------------------------

`timescale 1ns/1ps

interface fpu_result_if;

  import fpu_types_pkg::*;

  logic    valid;
  logic    ready;
  fp16_t   result;
  status_t status;
  tag_t    tag;

  // Payload holds steady while valid waits for ready
  modport group (output valid, result, status, tag, input ready);
  modport arb   (input valid, result, status, tag, output ready);

endinterface

//--- source/fpu_top.sv
// ---------------------------------------------------------------------
// FP16 floating-point unit
// Steers requests to the operation groups and merges their results
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module fpu_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Request
  input  fpu_types_pkg::fp16_t [1:0]   operands_i,
  input  fpu_types_pkg::fpu_op_e       op_i,
  input  fpu_types_pkg::tag_t          tag_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         flush_i,
  // Result
  output fpu_types_pkg::fp16_t         result_o,
  output fpu_types_pkg::status_t       status_o,
  output fpu_types_pkg::tag_t          tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  // Anything in flight
  output logic                         busy_o
);

  import fpu_cfg_pkg::*;
  import fpu_types_pkg::*;

  localparam int unsigned IDX_NC  = GRP_NONCOMP;
  localparam int unsigned IDX_MUL = GRP_MUL;

  opgroup_e                grp;
  logic [NUM_OPGROUPS-1:0] grp_in_valid, grp_in_ready;
  logic                    mul_busy;

  fpu_result_if res_if [NUM_OPGROUPS] ();

  // ------------------------------------------------------------------
  // Input steering
  // ------------------------------------------------------------------
  assign grp = (op_i == OP_MUL) ? GRP_MUL : GRP_NONCOMP;

  for (genvar g = 0; g < int'(NUM_OPGROUPS); g++) begin : gen_steer
    assign grp_in_valid[g] = in_valid_i & (grp == opgroup_e'(g));
  end

  assign in_ready_o = in_valid_i & grp_in_ready[grp];

  // ------------------------------------------------------------------
  // Operation groups
  // ------------------------------------------------------------------
  fpu_noncomp u_noncomp (
    .clk_i      ( clk_i                ),
    .arst_n_i   ( arst_n_i             ),
    .op_a_i     ( operands_i[0]        ),
    .op_b_i     ( operands_i[1]        ),
    .op_i       ( op_i                 ),
    .tag_i      ( tag_i                ),
    .in_valid_i ( grp_in_valid[IDX_NC] ),
    .in_ready_o ( grp_in_ready[IDX_NC] ),
    .flush_i    ( flush_i              ),
    .res        ( res_if[IDX_NC]       )
  );

  fpu_mul u_mul (
    .clk_i      ( clk_i                 ),
    .arst_n_i   ( arst_n_i              ),
    .op_a_i     ( operands_i[0]         ),
    .op_b_i     ( operands_i[1]         ),
    .tag_i      ( tag_i                 ),
    .in_valid_i ( grp_in_valid[IDX_MUL] ),
    .in_ready_o ( grp_in_ready[IDX_MUL] ),
    .flush_i    ( flush_i               ),
    .res        ( res_if[IDX_MUL]       ),
    .busy_o     ( mul_busy              )
  );

  // Results may leave out of order, the tag identifies them
  fpu_result_arbiter u_arbiter (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .flush_i     ( flush_i     ),
    .grp         ( res_if      ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       )
  );

  assign busy_o = mul_busy | res_if[IDX_NC].valid;

endmodule

//--- source/fpu_types_pkg.sv
// ---------------------------------------------------------------------
// FPU types package
// FP16 field widths, data types and operation encodings
// ---------------------------------------------------------------------

package fpu_types_pkg;

  import fpu_cfg_pkg::*;

  // FP16 field layout
  localparam int unsigned EXP_WIDTH = 5;
  localparam int unsigned MAN_WIDTH = 10;
  localparam int unsigned EXP_BIAS  = 15;

  // Sign, exponent and mantissa packed as in memory
  typedef logic [EXP_WIDTH+MAN_WIDTH:0] fp16_t;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  // Flags as {invalid, div-by-zero, overflow, underflow, inexact}
  typedef logic [4:0] status_t;

  typedef enum logic [3:0] {
    OP_MUL,
    OP_MIN,
    OP_MAX,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_CLASS
  } fpu_op_e;

  typedef enum logic {
    GRP_NONCOMP = 1'b0,
    GRP_MUL     = 1'b1
  } opgroup_e;

endpackage

//--- testbench/fpu_top_chk.sv
// ---------------------------------------------------------------------
// FPU handshake checker
// Bound to the top level, watches the output stall and flush rules
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module fpu_top_chk (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   in_valid_i,
  input logic                   in_ready_i,
  input logic                   flush_i,
  input logic                   out_valid_i,
  input logic                   out_ready_i,
  input fpu_types_pkg::fp16_t   result_i,
  input fpu_types_pkg::status_t status_i,
  input fpu_types_pkg::tag_t    tag_i
);

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_ready_i |-> in_valid_i)
    else $error("in_ready_o high without in_valid_i");

  no_accept_on_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |-> !in_ready_i)
    else $error("in_ready_o high during flush_i");

  flush_empties_output: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !out_valid_i)
    else $error("out_valid_o high in the cycle after flush_i");

  stall_keeps_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_i && !out_ready_i && !flush_i) |=> out_valid_i)
    else $error("out_valid_o dropped while stalled");

  // A stalled item keeps its whole payload until it transfers
  stall_keeps_payload: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_i && !out_ready_i && !flush_i)
    |=> ($stable(result_i) && $stable(status_i) && $stable(tag_i)))
    else $error("result_o, status_o or tag_o changed while stalled");

endmodule

bind fpu_top fpu_top_chk u_chk (
  .clk_i       ( clk_i       ),
  .arst_n_i    ( arst_n_i    ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_i  ( in_ready_o  ),
  .flush_i     ( flush_i     ),
  .out_valid_i ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .result_i    ( result_o    ),
  .status_i    ( status_o    ),
  .tag_i       ( tag_o       )
);

//--- testbench/fpu_top_tb.sv
// ---------------------------------------------------------------------
// FP16 unit testbench
// Random requests checked by tag against a reference model
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module fpu_top_tb;

  import fpu_cfg_pkg::*;
  import fpu_types_pkg::*;

  localparam int NTAGS      = 2 ** TAG_WIDTH;
  localparam int WAIT_LIMIT = 200;

  logic        clk = 1'b0;
  logic        arst_n;
  fp16_t [1:0] operands;
  fpu_op_e     req_op;
  tag_t        req_tag;
  logic        in_valid, in_ready, flush;
  fp16_t       result;
  status_t     status;
  tag_t        res_tag;
  logic        out_valid, out_ready, busy;

  // Scoreboard by tag, entries are {result, status}
  logic [20:0]      expected [NTAGS];
  logic [NTAGS-1:0] in_flight;
  tag_t             next_tag;
  logic [31:0]      rng_state;
  logic             out_seen, busy_seen;
  int               transfers;

  fpu_top u_fpu_top (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .operands_i  ( operands  ),
    .op_i        ( req_op    ),
    .tag_i       ( req_tag   ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( res_tag   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------------
  // Stimulus sources
  // ------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Half of the operands are special or near the exponent limits
  function automatic fp16_t pick_operand();
    logic [31:0] r;
    logic [4:0]  e;
    r = next_rand();
    case (r[3:0])
      4'd0: return {r[31], 15'h0};
      4'd1: return {r[31], 5'h1f, 10'h0};
      4'd2: return {r[31], 5'h1f, 1'b1, r[12:4]};
      4'd3: return {r[31], 5'h1f, 1'b0, r[12:5], 1'b1};
      4'd4: return {r[31], 5'h00, r[13:5], 1'b1};
      4'd5: begin
        e = r[4] ? 5'd30 : {4'b1110, r[5]};
        return {r[31], e, r[15:6]};
      end
      4'd6: begin
        e = 5'(r[6:4]) + 5'd1;
        return {r[31], e, r[16:7]};
      end
      default: return r[30:15];
    endcase
  endfunction

  function automatic fpu_op_e noncomp_op();
    logic [31:0] r;
    r = next_rand();
    return fpu_op_e'(4'(32'd1 + r % 32'd9));
  endfunction

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  function automatic logic is_nan(input fp16_t v);
    return (v[14:10] == 5'h1f) && (v[9:0] != 10'h0);
  endfunction

  function automatic logic is_snan(input fp16_t v);
    return is_nan(v) && !v[9];
  endfunction

  // Integer key with -0 just below +0
  function automatic int order_key(input fp16_t v);
    return v[15] ? -int'(v[14:0]) - 1 : int'(v[14:0]);
  endfunction

  function automatic logic [9:0] class_mask(input fp16_t v);
    logic [9:0] mask;
    int         idx;
    if (v[14:10] == 5'h1f && v[9:0] == 10'h0) idx = v[15] ? 0 : 7;
    else if (v[14:10] == 5'h1f)              idx = v[9] ? 9 : 8;
    else if (v[14:0] == 15'h0)               idx = v[15] ? 3 : 4;
    else if (v[14:10] == 5'h0)               idx = v[15] ? 2 : 5;
    else                                     idx = v[15] ? 1 : 6;
    mask      = '0;
    mask[idx] = 1'b1;
    return mask;
  endfunction

  function automatic logic [20:0] model_noncomp(input fpu_op_e op, input fp16_t a,
                                                input fp16_t b);
    logic any_nan, any_snan, zeros, lt, eq;
    int   ka, kb;
    any_nan  = is_nan(a) || is_nan(b);
    any_snan = is_snan(a) || is_snan(b);
    zeros    = (a[14:0] == 15'h0) && (b[14:0] == 15'h0);
    ka       = order_key(a);
    kb       = order_key(b);
    lt       = (ka < kb) && !zeros;
    eq       = (a == b) || zeros;
    case (op)
      OP_MIN, OP_MAX: begin
        if (is_nan(a) && is_nan(b)) return {CANON_NAN, any_snan, 4'h0};
        if (is_nan(a)) return {b, any_snan, 4'h0};
        if (is_nan(b)) return {a, any_snan, 4'h0};
        if ((ka < kb) == (op == OP_MIN)) return {a, any_snan, 4'h0};
        return {b, any_snan, 4'h0};
      end
      OP_SGNJ:  return {b[15], a[14:0], 5'h0};
      OP_SGNJN: return {~b[15], a[14:0], 5'h0};
      OP_SGNJX: return {a[15] ^ b[15], a[14:0], 5'h0};
      OP_FEQ:   return {15'h0, eq && !any_nan, any_snan, 4'h0};
      OP_FLT:   return {15'h0, lt && !any_nan, any_nan, 4'h0};
      OP_FLE:   return {15'h0, (lt || eq) && !any_nan, any_nan, 4'h0};
      OP_CLASS: return {6'h0, class_mask(a), 5'h0};
      default:  return '0;
    endcase
  endfunction

  // Truncating multiply, subnormal inputs count as zero
  function automatic logic [20:0] model_mul(input fp16_t a, input fp16_t b);
    logic        s, za, zb, ia, ib, lost;
    logic [21:0] p;
    logic [9:0]  man;
    int          e;
    s  = a[15] ^ b[15];
    za = (a[14:10] == 5'h0);
    zb = (b[14:10] == 5'h0);
    ia = (a[14:10] == 5'h1f) && !is_nan(a);
    ib = (b[14:10] == 5'h1f) && !is_nan(b);
    if (is_nan(a) || is_nan(b)) return {CANON_NAN, is_snan(a) || is_snan(b), 4'h0};
    if ((ia && zb) || (ib && za)) return {CANON_NAN, 5'b10000};
    if (ia || ib) return {s, 5'h1f, 10'h0, 5'h0};
    if (za || zb) return {s, 15'h0, 5'h0};
    p = 22'({1'b1, a[9:0]}) * 22'({1'b1, b[9:0]});
    e = int'(a[14:10]) + int'(b[14:10]) - 15;
    if (p[21]) begin
      e    = e + 1;
      man  = p[20:11];
      lost = |p[10:0];
    end else begin
      man  = p[19:10];
      lost = |p[9:0];
    end
    if (e >= 31) return {s, FP_MAX_FINITE[14:0], 5'b00101};
    if (e < 1) return {s, 15'h0, 5'b00011};
    return {s, e[4:0], man, 4'h0, lost};
  endfunction

  // ------------------------------------------------------------------
  // Scoreboard and cycle driver
  // ------------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_output();
    logic [20:0] exp_val;
    exp_val = expected[res_tag];
    assert (in_flight[res_tag])
      else fail_run($sformatf("Result with tag %0h arrived while not in flight", res_tag));
    assert (result == exp_val[20:5])
      else fail_run($sformatf("** Error result_o (tag %h): got %h, expected %h",
                              res_tag, result, exp_val[20:5]));
    assert (status == exp_val[4:0])
      else fail_run($sformatf("** Error status_o (tag %h): got %h, expected %h",
                              res_tag, status, exp_val[4:0]));
    in_flight[res_tag] = 1'b0;
    transfers++;
  endtask

  task automatic run_cycle(input logic req, input fpu_op_e op, input fp16_t a,
                           input fp16_t b, input logic rdy, input logic flush_req);
    tag_t cand, pick;
    logic have_tag;
    have_tag = 1'b0;
    pick     = '0;
    for (int i = 0; i < NTAGS; i++) begin
      cand = tag_t'(int'(next_tag) + i);
      if (!have_tag && !in_flight[cand]) begin
        have_tag = 1'b1;
        pick     = cand;
      end
    end
    @(negedge clk);
    in_valid    = req & have_tag;
    req_op      = op;
    operands[0] = a;
    operands[1] = b;
    req_tag     = pick;
    out_ready   = rdy;
    flush       = flush_req;
    // Sample just before the rising edge, when everything has settled
    #4;
    out_seen  = out_valid & out_ready;
    busy_seen = busy;
    if (out_seen) check_output();
    if (in_valid && in_ready) begin
      expected[pick]  = (op == OP_MUL) ? model_mul(a, b) : model_noncomp(op, a, b);
      in_flight[pick] = 1'b1;
      next_tag        = tag_t'(int'(pick) + 1);
    end
    if (flush) in_flight = '0;
    @(posedge clk);
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (in_flight != '0) begin
      assert (waited < WAIT_LIMIT)
        else fail_run("Timeout while waiting for in-flight results to drain");
      run_cycle(1'b0, OP_MIN, '0, '0, 1'b1, 1'b0);
      waited++;
    end
  endtask

  // mix 0 is noncomp only, 1 is mul only, 2 mixes both groups
  task automatic random_traffic(input int cycles, input int mix, input int ready_pct);
    logic [31:0] r;
    fpu_op_e     op;
    logic        rdy;
    fp16_t       a, b;
    for (int i = 0; i < cycles; i++) begin
      r = next_rand();
      if (mix == 0)      op = noncomp_op();
      else if (mix == 1) op = OP_MUL;
      else               op = r[0] ? OP_MUL : noncomp_op();
      rdy = int'(r[15:8] % 8'd100) < ready_pct;
      a   = pick_operand();
      b   = pick_operand();
      run_cycle(r[1] | r[2] | (mix != 2), op, a, b, rdy, 1'b0);
    end
  endtask

  task automatic check_latency(input fpu_op_e op, input int lat);
    int cycles;
    run_cycle(1'b1, op, pick_operand(), pick_operand(), 1'b1, 1'b0);
    assert (in_flight != '0) else fail_run("Lone request was not accepted");
    cycles = 0;
    while (!out_seen) begin
      assert (cycles < WAIT_LIMIT) else fail_run("Timeout waiting for a lone result");
      run_cycle(1'b0, OP_MIN, '0, '0, 1'b1, 1'b0);
      cycles++;
    end
    assert (cycles == lat)
      else fail_run($sformatf("** Error out_valid_o latency for %s: got %h, expected %h",
                              op.name(), cycles, lat));
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    rng_state   = 32'd490;
    arst_n      = 1'b0;
    operands    = '0;
    req_op      = OP_MIN;
    req_tag     = '0;
    in_valid    = 1'b0;
    flush       = 1'b0;
    out_ready   = 1'b0;
    in_flight   = '0;
    next_tag    = '0;
    transfers   = 0;
    out_seen    = 1'b0;
    busy_seen   = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    #4;
    assert (!out_valid)
      else fail_run($sformatf("** Error out_valid_o after reset: got %h, expected 0", out_valid));
    assert (!in_ready)
      else fail_run($sformatf("** Error in_ready_o after reset: got %h, expected 0", in_ready));
    assert (!busy)
      else fail_run($sformatf("** Error busy_o after reset: got %h, expected 0", busy));

    random_traffic(300, 0, 100);
    drain_results();
    random_traffic(300, 1, 100);
    drain_results();
    random_traffic(800, 2, 70);
    drain_results();
    check_latency(OP_FLE, 1);
    check_latency(OP_MUL, 2);

    // Stall the output so both groups fill up, then flush
    random_traffic(6, 2, 0);
    assert (in_flight != '0) else fail_run("No request was in flight before the flush");
    run_cycle(1'b1, OP_MUL, pick_operand(), pick_operand(), 1'b0, 1'b1);
    assert (busy_seen)
      else fail_run($sformatf("** Error busy_o before flush: got %h, expected 1", busy_seen));
    run_cycle(1'b0, OP_MIN, '0, '0, 1'b1, 1'b0);
    assert (!busy_seen)
      else fail_run($sformatf("** Error busy_o after flush: got %h, expected 0", busy_seen));
    random_traffic(200, 2, 80);
    drain_results();

    $display("Results checked: %0d", transfers);
    $display("NO ERRORS");
    $finish;
  end

endmodule
